// File: source/lm_req_pkg.sv
// Lane master request protocol codes and bus widths
package lm_req_pkg;

    // Request code width and bus widths
    localparam int RQ_CODE_W = 5;            // Width of one request code
    localparam int RQI_W     = 6;            // Initiate bus {code, enable}
    localparam int RQR_W     = 2;            // Response bus {rdata, done}

    // Codes carried in the upper bits of the initiate bus
    typedef enum logic [RQ_CODE_W-1:0] {
        RQC_L2R       = 5'd1,                // CDR lock to reference
        RQC_L2D       = 5'd2,                // CDR lock to data
        RQC_READ_DFC  = 5'd3,                // Read DONE_FULL_CAL
        RQC_PCSRST0   = 5'd4,                // Release soft PCS Rx reset
        RQC_PCSRST1   = 5'd5,                // Assert soft PCS Rx reset
        RQC_TGLCALRST = 5'd6,                // Pulse DFE_CAL_RST
        RQC_TGLRUNCAL = 5'd7                 // Pulse DFE_RUN_FULL_CAL
    } rq_code_e;

endpackage

// File: source/lm_seq_pkg.sv
// Lane master sequencer states and input synchronizer depth
package lm_seq_pkg;

    // Flops per synchronizer chain
    // Edge detection on the request uses one extra stage
    localparam int SYNC_STAGES = 2;

    // Lock management and calibration states
    typedef enum logic [3:0] {
        ST_IDLE     = 4'd0,                  // Waiting for a lock change or calibration request
        ST_SET_LOCK = 4'd1,                  // L2R or L2D outstanding
        ST_ACK_LOCK = 4'd2,                  // Lock state flipped
        ST_WAIT_RDY = 4'd3,                  // Waiting for synchronized RX ready
        ST_PRE_POLL = 4'd4,                  // First poll tick
        ST_POLL_TMR = 4'd5,                  // Poll timer tick
        ST_READ_DFC = 4'd6,                  // DONE_FULL_CAL read outstanding
        ST_CHK_DONE = 4'd7,                  // Branch on read data
        ST_RX_OK    = 4'd8,                  // PCS reset release outstanding
        ST_PRE_CAL  = 4'd9,                  // One cycle before calibration
        ST_CAL1     = 4'd10,                 // PCS reset assert outstanding
        ST_CAL2     = 4'd11,                 // Cal reset toggle outstanding
        ST_CAL3     = 4'd12                  // Run-cal toggle outstanding
    } lm_state_e;

endpackage

// File: source/lm_req_if.sv
// Request handoff between the lane sequencer and the request port
`timescale 1ns/1ps

interface lm_req_if;
    import lm_req_pkg::*;

    logic     issue;                         // One-cycle start pulse
    rq_code_e code;                          // Valid with issue
    logic     busy;                          // Request outstanding
    logic     rdata;                         // Response bit 1 of the last completion

    // Sequencer side
    modport seq (
        output issue,
        output code,
        input  busy,
        input  rdata
    );

    // Request port side
    modport port (
        input  issue,
        input  code,
        output busy,
        output rdata
    );

endinterface

// File: source/lm_input_sync.sv
// Synchronizers and rising edge detect for the lane master's asynchronous inputs
`timescale 1ns/1ps

module lm_input_sync (
    input  logic CTRL_CLK,
    input  logic CTRL_SRST_N,
    input  logic i_rx_ready,                 // Async wrt CTRL_CLK
    input  logic i_calib_req,                // Async wrt CTRL_CLK
    output logic o_rx_ready_s,               // Synchronized RX ready
    output logic o_calib_req_rise            // One-cycle pulse on request rise
);
    import lm_seq_pkg::*;

    logic [SYNC_STAGES-1:0] rx_ready_sync;   // Ready chain
    logic [SYNC_STAGES:0]   calib_req_sync;  // Request chain plus edge stage
    logic                   calib_rise_q;

    // RX ready chain clears to not ready
    always_ff @(posedge CTRL_CLK or negedge CTRL_SRST_N) begin
        if (!CTRL_SRST_N) begin
            rx_ready_sync <= '0;
        end else begin
            rx_ready_sync <= {rx_ready_sync[SYNC_STAGES-2:0], i_rx_ready};
        end
    end

    // Request chain clears to all ones
    // A request already high out of reset is then not an edge
    always_ff @(posedge CTRL_CLK or negedge CTRL_SRST_N) begin
        if (!CTRL_SRST_N) begin
            calib_req_sync <= '1;
        end else begin
            calib_req_sync <= {calib_req_sync[SYNC_STAGES-1:0], i_calib_req};
        end
    end

    // Registered edge pulse
    always_ff @(posedge CTRL_CLK or negedge CTRL_SRST_N) begin
        if (!CTRL_SRST_N) begin
            calib_rise_q <= 1'b0;
        end else begin
            calib_rise_q <= calib_req_sync[SYNC_STAGES-1] & ~calib_req_sync[SYNC_STAGES];
        end
    end

    assign o_rx_ready_s     = rx_ready_sync[SYNC_STAGES-1];  // Last ready stage
    assign o_calib_req_rise = calib_rise_q;

endmodule

// File: source/lm_sequencer.sv
// Lane sequencer for CDR lock changes, full DFE calibration and done polling
`timescale 1ns/1ps

module lm_sequencer #(
    parameter bit p_auto_cal = 1'b0          // 1 = calibrate on first bit-lock
) (
    input  logic  CTRL_CLK,
    input  logic  CTRL_SRST_N,
    lm_req_if.seq req,                       // To the request port
    input  logic  i_poll_tick,               // Link timer poll tick
    input  logic  i_lckfrc,                  // 1 = lock to reference
    input  logic  i_rx_ready_s,              // Synchronized RX ready
    input  logic  i_calib_req_rise,          // On-demand calibration pulse
    output logic  o_lckfrc,                  // Current lock state
    output logic  o_rx_ok,
    output logic  o_calibrating,
    output logic  o_calib_sync_hold
);
    import lm_req_pkg::*;
    import lm_seq_pkg::*;

    lm_state_e state_q;
    lm_state_e state_nx;
    logic      lckfrc_q;                     // Lock state seen by the CDR
    logic      rx_ok_q;
    logic      sync_hold_q;
    logic      calib_q;                      // Inverse of last DONE_FULL_CAL
    logic      first_cal_q;                  // A calibration result was checked
    logic      cal_req_q;                    // Latched on-demand request
    logic      req_exit;                     // Outstanding request finished
    logic      entering;                     // State changes this cycle
    logic      issue_c;
    rq_code_e  code_c;

    assign req_exit = ~req.busy;
    assign entering = (state_nx != state_q);

    // Next state
    always_comb begin
        state_nx = state_q;
        case (state_q)
            ST_IDLE: begin
                if (i_lckfrc != lckfrc_q) begin
                    state_nx = ST_SET_LOCK;          // Lock change wins
                end else if (cal_req_q && !lckfrc_q) begin
                    state_nx = ST_PRE_CAL;           // On demand, lock to data only
                end
            end
            ST_SET_LOCK: if (req_exit) state_nx = ST_ACK_LOCK;
            ST_ACK_LOCK: begin
                // lckfrc_q already holds the new lock state here
                if (lckfrc_q) state_nx = ST_IDLE;
                else          state_nx = ST_WAIT_RDY;
            end
            ST_WAIT_RDY: begin
                if (i_rx_ready_s && p_auto_cal && !first_cal_q) begin
                    state_nx = ST_PRE_CAL;           // First bit-lock
                end else if (i_rx_ready_s) begin
                    state_nx = ST_PRE_POLL;
                end
            end
            ST_PRE_POLL: if (i_poll_tick) state_nx = ST_POLL_TMR;
            ST_POLL_TMR: if (i_poll_tick) state_nx = ST_READ_DFC;
            ST_READ_DFC: if (req_exit) state_nx = ST_CHK_DONE;
            ST_CHK_DONE: begin
                if (!calib_q) state_nx = ST_RX_OK;  // Calibration finished
                else          state_nx = ST_POLL_TMR;
            end
            ST_RX_OK:    if (req_exit) state_nx = ST_IDLE;
            ST_PRE_CAL:  state_nx = ST_CAL1;
            ST_CAL1:     if (req_exit) state_nx = ST_CAL2;
            ST_CAL2:     if (req_exit) state_nx = ST_CAL3;
            ST_CAL3:     if (req_exit) state_nx = ST_POLL_TMR;
            default:     state_nx = ST_IDLE;
        endcase
    end

    // One request per request state, issued on entry
    // busy is high from the next cycle, so req_exit marks completion
    always_comb begin
        issue_c = 1'b0;
        code_c  = RQC_L2R;
        case (state_nx)
            ST_SET_LOCK: begin
                issue_c = entering;
                code_c  = i_lckfrc ? RQC_L2R : RQC_L2D;
            end
            ST_READ_DFC: begin
                issue_c = entering;
                code_c  = RQC_READ_DFC;
            end
            ST_RX_OK: begin
                issue_c = entering;
                code_c  = RQC_PCSRST0;
            end
            ST_CAL1: begin
                issue_c = entering;
                code_c  = RQC_PCSRST1;
            end
            ST_CAL2: begin
                issue_c = entering;
                code_c  = RQC_TGLCALRST;
            end
            ST_CAL3: begin
                issue_c = entering;
                code_c  = RQC_TGLRUNCAL;
            end
            default: issue_c = 1'b0;
        endcase
    end

    assign req.issue = issue_c;
    assign req.code  = code_c;

    // State and status flags
    always_ff @(posedge CTRL_CLK or negedge CTRL_SRST_N) begin
        if (!CTRL_SRST_N) begin
            state_q     <= ST_IDLE;
            lckfrc_q    <= 1'b1;                 // Out of reset locked to reference
            rx_ok_q     <= 1'b0;
            sync_hold_q <= 1'b0;
            calib_q     <= 1'b0;
            first_cal_q <= 1'b0;
            cal_req_q   <= 1'b0;
        end else begin
            state_q <= state_nx;

            if (state_nx == ST_ACK_LOCK) lckfrc_q <= ~lckfrc_q;

            // RX ok drops on lock change and on PCS reset assert
            if (issue_c && code_c inside {RQC_L2R, RQC_L2D, RQC_PCSRST1}) begin
                rx_ok_q <= 1'b0;
            end else if (issue_c && code_c == RQC_PCSRST0) begin
                rx_ok_q <= 1'b1;
            end

            // Hold spans the whole calibration up to idle
            if (issue_c && code_c == RQC_PCSRST1) begin
                sync_hold_q <= 1'b1;
            end else if (state_nx == ST_IDLE) begin
                sync_hold_q <= 1'b0;
            end

            // rdata is valid in the cycle busy falls
            if (state_nx == ST_CHK_DONE) begin
                calib_q     <= ~req.rdata;
                first_cal_q <= 1'b1;
            end

            // Requests only count while the lane is up
            if (!rx_ok_q) begin
                cal_req_q <= 1'b0;
            end else if (i_calib_req_rise) begin
                cal_req_q <= 1'b1;
            end
        end
    end

    assign o_lckfrc          = lckfrc_q;
    assign o_rx_ok           = rx_ok_q;
    assign o_calibrating     = calib_q;
    assign o_calib_sync_hold = sync_hold_q;

endmodule

// File: source/lm_request_port.sv
// Request port holding the outstanding lane request and its initiate/response handshake
`timescale 1ns/1ps

module lm_request_port (
    input  logic                        CTRL_CLK,
    input  logic                        CTRL_SRST_N,
    lm_req_if.port                      req,          // From the sequencer
    input  logic                        i_m_grant,    // Arbiter grant
    input  logic [lm_req_pkg::RQR_W-1:0] i_rqr,       // {rdata, done}
    output logic                        o_m_request,  // Request outstanding
    output logic [lm_req_pkg::RQI_W-1:0] o_rqi        // {code, enable}
);
    import lm_req_pkg::*;

    rq_code_e code_q;                        // Stable until completion
    logic     en_q;                          // Enable bit of the initiate bus
    logic     rdata_q;
    logic     rq_done;

    // Completes on the first cycle with grant and done
    assign rq_done = en_q & i_m_grant & i_rqr[0];

    // Code and enable
    always_ff @(posedge CTRL_CLK or negedge CTRL_SRST_N) begin
        if (!CTRL_SRST_N) begin
            code_q <= RQC_L2R;
            en_q   <= 1'b0;
        end else begin
            if (req.issue) begin
                code_q <= req.code;
                en_q   <= 1'b1;
            end else if (rq_done) begin
                en_q   <= 1'b0;                  // Code held, only enable drops
            end
        end
    end

    // Read data from the completing response
    always_ff @(posedge CTRL_CLK) begin
        if (rq_done) rdata_q <= i_rqr[1];
    end

    assign req.busy    = en_q;
    assign req.rdata   = rdata_q;
    assign o_m_request = en_q;               // Same as the enable bit
    assign o_rqi       = {code_q, en_q};

endmodule

// File: source/lane_master_top.sv
// Lane master top joining the input synchronizer, sequencer and request port
`timescale 1ns/1ps

module lane_master_top #(
    parameter bit p_auto_cal = 1'b0          // 1 = calibrate on first bit-lock
) (
    input  logic                         CTRL_CLK,
    input  logic                         CTRL_SRST_N,
    // Link timer
    input  logic                         i_poll_tick,
    // Lock management
    input  logic                         i_lckfrc,
    output logic                         o_lckfrc,
    // Arbiter and request bus
    input  logic                         i_m_grant,
    output logic                         o_m_request,
    output logic [lm_req_pkg::RQI_W-1:0] o_rqi,
    input  logic [lm_req_pkg::RQR_W-1:0] i_rqr,
    // Transceiver
    input  logic                         i_rx_ready,   // Async
    // Fabric side
    input  logic                         i_calib_req,  // Async
    output logic                         o_calibrating,
    output logic                         o_rx_ok,
    output logic                         o_calib_sync_hold
);

    logic rx_ready_s;                        // Synchronized ready
    logic calib_req_rise;                    // Request rise pulse

    lm_req_if u_req_if ();                   // Sequencer to port handoff

    lm_input_sync u_input_sync (
        .CTRL_CLK         (CTRL_CLK),
        .CTRL_SRST_N      (CTRL_SRST_N),
        .i_rx_ready       (i_rx_ready),
        .i_calib_req      (i_calib_req),
        .o_rx_ready_s     (rx_ready_s),
        .o_calib_req_rise (calib_req_rise)
    );

    lm_sequencer #(
        .p_auto_cal (p_auto_cal)
    ) u_sequencer (
        .CTRL_CLK          (CTRL_CLK),
        .CTRL_SRST_N       (CTRL_SRST_N),
        .req               (u_req_if.seq),
        .i_poll_tick       (i_poll_tick),
        .i_lckfrc          (i_lckfrc),
        .i_rx_ready_s      (rx_ready_s),
        .i_calib_req_rise  (calib_req_rise),
        .o_lckfrc          (o_lckfrc),
        .o_rx_ok           (o_rx_ok),
        .o_calibrating     (o_calibrating),
        .o_calib_sync_hold (o_calib_sync_hold)
    );

    lm_request_port u_request_port (
        .CTRL_CLK    (CTRL_CLK),
        .CTRL_SRST_N (CTRL_SRST_N),
        .req         (u_req_if.port),
        .i_m_grant   (i_m_grant),
        .i_rqr       (i_rqr),
        .o_m_request (o_m_request),
        .o_rqi       (o_rqi)
    );

endmodule

// File: testbench/tb_clk_gen.sv
// Testbench clock and reset source for the lane master
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int p_period_ns  = 10,
    parameter int p_rst_cycles = 10          // Reset held for this many edges
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(p_period_ns / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;                      // Asserted from time zero
        repeat (p_rst_cycles) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

// File: testbench/lane_master_checker.sv
// Lane master protocol and status flag assertions
`timescale 1ns/1ps

module lane_master_checker (
    input logic                         CTRL_CLK,
    input logic                         CTRL_SRST_N,
    input logic                         i_issue,        // Sequencer start pulse
    input logic                         i_busy,
    input logic                         i_m_request,
    input logic [lm_req_pkg::RQI_W-1:0] i_rqi,
    input logic                         i_done,         // Grant and done together
    input logic                         i_calibrating,
    input logic                         i_rx_ok
);
    import lm_req_pkg::*;

    int fail_cnt = 0;                        // Failed assertion count

    // Code field frozen for the life of a request
    a_code_stable: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_SRST_N)
        (i_m_request && $past(i_m_request)) |-> $stable(i_rqi[RQI_W-1:1]))
        else begin
            fail_cnt++;
            $error("Request code changed while the request was outstanding");
        end

    // Enable drops right after completion
    a_en_fall: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_SRST_N)
        (i_m_request && i_done) |=> !i_m_request)
        else begin
            fail_cnt++;
            $error("Enable bit still high one cycle after completion");
        end

    a_no_issue_busy: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_SRST_N)
        i_issue |-> !i_busy)
        else begin
            fail_cnt++;
            $error("Request issued while the previous one was busy");
        end

    a_cal_vs_ok: assert property (@(posedge CTRL_CLK) disable iff (!CTRL_SRST_N)
        !(i_calibrating && i_rx_ok))
        else begin
            fail_cnt++;
            $error("Calibrating and rx ok high together");
        end

endmodule

// Handshake side
bind lm_request_port lane_master_checker u_port_checker (
    .CTRL_CLK      (CTRL_CLK),
    .CTRL_SRST_N   (CTRL_SRST_N),
    .i_issue       (req.issue),
    .i_busy        (req.busy),
    .i_m_request   (o_m_request),
    .i_rqi         (o_rqi),
    .i_done        (i_m_grant & i_rqr[0]),
    .i_calibrating (1'b0),
    .i_rx_ok       (1'b0)
);

// Sequencer side where busy is the inverse of req_exit
bind lm_sequencer lane_master_checker u_seq_checker (
    .CTRL_CLK      (CTRL_CLK),
    .CTRL_SRST_N   (CTRL_SRST_N),
    .i_issue       (issue_c),
    .i_busy        (~req_exit),
    .i_m_request   (1'b0),
    .i_rqi         ('0),
    .i_done        (1'b0),
    .i_calibrating (calib_q),
    .i_rx_ok       (rx_ok_q)
);

// File: testbench/tb_lane_master.sv
// Lane master testbench with scenario table, request responder and watchdog
`timescale 1ns/1ps

module tb_lane_master;
    import lm_req_pkg::*;
    import lm_seq_pkg::*;

    localparam int MAX_ROWS = 8, MAX_CODES = 12;
    localparam int TICK_PERIOD = 16, QUIET_CYCLES = 64, RST_CYCLES = 10;

    logic CTRL_CLK, CTRL_SRST_N;
    logic i_poll_tick, i_lckfrc, i_m_grant, i_rx_ready, i_calib_req;
    logic [RQR_W-1:0] i_rqr;
    logic [RQI_W-1:0] o_rqi;
    logic o_lckfrc, o_m_request, o_calibrating, o_rx_ok, o_calib_sync_hold;

    // Scenario table with one column per array
    int       n_rows, tab_polls [MAX_ROWS], tab_ncodes [MAX_ROWS];
    logic     tab_lckfrc [MAX_ROWS], tab_pulse [MAX_ROWS];
    logic     tab_rx_ok [MAX_ROWS], tab_cal [MAX_ROWS], tab_lk [MAX_ROWS];
    rq_code_e tab_codes [MAX_ROWS][MAX_CODES];
    logic     table_loaded = 1'b0;

    rq_code_e    code_log [$];                 // Completed codes of the current row
    int          read_cnt, row_polls;          // DONE_FULL_CAL reads so far and N
    logic [31:0] lfsr;
    int          rx_rise_cnt, lck_chg_cnt;
    logic        rx_ok_prev, lckfrc_prev, seen_cal, seen_hold, seen_rx_low;

    tb_clk_gen #(.p_period_ns(10), .p_rst_cycles(RST_CYCLES)) u_clk_gen (
        .o_clk (CTRL_CLK), .o_rst_n (CTRL_SRST_N)
    );

    lane_master_top #(.p_auto_cal(1'b1)) dut_i (
        .CTRL_CLK (CTRL_CLK), .CTRL_SRST_N (CTRL_SRST_N), .i_poll_tick (i_poll_tick),
        .i_lckfrc (i_lckfrc), .o_lckfrc (o_lckfrc), .i_m_grant (i_m_grant),
        .o_m_request (o_m_request), .o_rqi (o_rqi), .i_rqr (i_rqr), .i_rx_ready (i_rx_ready),
        .i_calib_req (i_calib_req), .o_calibrating (o_calibrating), .o_rx_ok (o_rx_ok),
        .o_calib_sync_hold (o_calib_sync_hold)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic check_code(input string name, input rq_code_e got, input rq_code_e exp);
        if (got !== exp)
            fail_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            fail_run($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    // Galois LFSR for x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic int draw_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            v    = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    task automatic add_row(input logic lck, pulse, input int polls, input logic ok, cal, lk);
        tab_lckfrc[n_rows] = lck;
        tab_pulse[n_rows]  = pulse;
        tab_polls[n_rows]  = polls;
        tab_ncodes[n_rows] = 0;
        tab_rx_ok[n_rows]  = ok;
        tab_cal[n_rows]    = cal;
        tab_lk[n_rows]     = lk;
        n_rows++;
    endtask

    task automatic add_code(input rq_code_e c);
        tab_codes[n_rows-1][tab_ncodes[n_rows-1]] = c;
        tab_ncodes[n_rows-1]++;
    endtask

    // Polls and PCS reset release behind an optional full cal sequence
    task automatic add_tail(input logic with_cal, input int polls);
        if (with_cal) begin
            add_code(RQC_PCSRST1);
            add_code(RQC_TGLCALRST);
            add_code(RQC_TGLRUNCAL);
        end
        repeat (polls) add_code(RQC_READ_DFC);
        add_code(RQC_PCSRST0);
    endtask

    task automatic build_table();
        n_rows = 0;
        add_row(1, 0, 0, 0, 0, 1);           // Stay on reference
        add_row(0, 0, 3, 1, 0, 0);           // Auto first cal
        add_code(RQC_L2D);
        add_tail(1, 3);
        add_row(0, 1, 2, 1, 0, 0);           // On demand
        add_tail(1, 2);
        add_row(1, 0, 0, 0, 0, 1);
        add_code(RQC_L2R);
        add_row(1, 1, 0, 0, 0, 1);           // Request ignored while the lane is down
        add_row(0, 0, 1, 1, 0, 0);           // Poll only
        add_code(RQC_L2D);
        add_tail(0, 1);
        add_row(0, 1, 4, 1, 0, 0);
        add_tail(1, 4);
        add_row(1, 0, 0, 0, 0, 1);
        add_code(RQC_L2R);
    endtask

    // One clock with end marker and seen flag tracking
    task automatic step();
        @(posedge CTRL_CLK);
        if (o_rx_ok && !rx_ok_prev) rx_rise_cnt++;
        if (o_lckfrc !== lckfrc_prev) lck_chg_cnt++;
        rx_ok_prev  = o_rx_ok;
        lckfrc_prev = o_lckfrc;
        seen_cal    |= o_calibrating;
        seen_hold   |= o_calib_sync_hold;
        seen_rx_low |= !o_rx_ok;
    endtask

    task automatic run_row(input int r);
        int   rise0, chg0;
        logic exp_hold, exp_low;
        exp_hold = 1'b0;
        exp_low  = 1'b1;                     // Lane down out of reset
        if (r > 0) exp_low = !tab_rx_ok[r-1];
        for (int k = 0; k < tab_ncodes[r]; k++) begin
            if (tab_codes[r][k] == RQC_PCSRST1) exp_hold = 1'b1;
            if (tab_codes[r][k] inside {RQC_L2R, RQC_L2D, RQC_PCSRST1}) exp_low = 1'b1;
        end
        code_log.delete();
        read_cnt    = 0;
        row_polls   = tab_polls[r];
        seen_cal    = 1'b0;
        seen_hold   = 1'b0;
        seen_rx_low = !o_rx_ok;
        rise0       = rx_rise_cnt;
        chg0        = lck_chg_cnt;
        i_lckfrc    <= tab_lckfrc[r];
        i_rx_ready  <= !tab_lckfrc[r];       // Receiver ready only when locked to data
        i_calib_req <= tab_pulse[r];
        repeat (SYNC_STAGES + 2) step();
        i_calib_req <= 1'b0;
        if (tab_ncodes[r] == 0) repeat (QUIET_CYCLES) step();
        else if (tab_rx_ok[r]) while (rx_rise_cnt == rise0) step();
        else while (lck_chg_cnt == chg0) step();
        while (o_m_request) step();          // Last request still in flight
        repeat (SYNC_STAGES + 2) step();
        if (code_log.size() != tab_ncodes[r])
            fail_run($sformatf("Row %0d completed %0d requests where %0d were expected",
                               r, code_log.size(), tab_ncodes[r]));
        for (int k = 0; k < tab_ncodes[r]; k++)
            check_code($sformatf("o_rqi code (row %0d, request %0d)", r, k),
                       code_log[k], tab_codes[r][k]);
        check_flag("o_rx_ok", o_rx_ok, tab_rx_ok[r]);
        check_flag("o_calibrating", o_calibrating, tab_cal[r]);
        check_flag("o_lckfrc", o_lckfrc, tab_lk[r]);
        check_flag("o_calib_sync_hold", o_calib_sync_hold, 1'b0);
        check_flag("o_calib_sync_hold seen high", seen_hold, exp_hold);
        check_flag("o_calibrating seen high", seen_cal, tab_polls[r] > 1);
        check_flag("o_rx_ok seen low", seen_rx_low, exp_low);
    endtask

    // Free-running poll tick
    initial begin
        int cnt;
        i_poll_tick <= 1'b0;
        cnt = 0;
        forever begin
            @(posedge CTRL_CLK);
            cnt = (cnt + 1) % TICK_PERIOD;
            i_poll_tick <= (cnt == 0);
        end
    end

    // Responder with a random grant delay then one completion cycle
    initial begin
        rq_code_e code;
        int       delay;
        logic     rbit;
        i_m_grant <= 1'b0;
        i_rqr     <= '0;
        lfsr = 32'hb4a8_4ca4;
        forever begin
            @(posedge CTRL_CLK);
            if (o_m_request) begin
                check_flag("o_rqi enable", o_rqi[0], 1'b1);
                code  = rq_code_e'(o_rqi[RQI_W-1:1]);
                delay = draw_bits(2);
                repeat (delay) @(posedge CTRL_CLK);
                rbit = 1'b0;
                if (code == RQC_READ_DFC) begin
                    read_cnt++;
                    rbit = (read_cnt == row_polls);  // Done only on the Nth read
                end
                i_m_grant <= 1'b1;
                i_rqr     <= {rbit, 1'b1};
                @(posedge CTRL_CLK);         // DUT completes here
                i_m_grant <= 1'b0;
                i_rqr     <= '0;
                code_log.push_back(code);
            end
        end
    end

    // Watch the bound checkers
    always @(posedge CTRL_CLK) begin
        if (dut_i.u_request_port.u_port_checker.fail_cnt != 0 ||
            dut_i.u_sequencer.u_seq_checker.fail_cnt != 0)
            fail_run("A checker assertion failed");
    end

    // Watchdog sized from the poll counts
    initial begin
        int budget;
        wait (table_loaded);
        budget = RST_CYCLES;
        for (int r = 0; r < n_rows; r++) budget += (tab_polls[r] + 4) * TICK_PERIOD * 8;
        repeat (budget) @(posedge CTRL_CLK);
        fail_run($sformatf("Watchdog expired after %0d cycles before the scenarios finished",
                           budget));
    end

    initial begin
        i_lckfrc    <= 1'b1;
        i_rx_ready  <= 1'b0;
        i_calib_req <= 1'b0;
        rx_rise_cnt = 0;
        lck_chg_cnt = 0;
        build_table();
        table_loaded = 1'b1;
        @(posedge CTRL_SRST_N);
        repeat (2) @(posedge CTRL_CLK);
        check_flag("o_m_request", o_m_request, 1'b0);
        check_flag("o_rqi enable", o_rqi[0], 1'b0);
        check_flag("o_rx_ok", o_rx_ok, 1'b0);
        check_flag("o_calibrating", o_calibrating, 1'b0);
        check_flag("o_calib_sync_hold", o_calib_sync_hold, 1'b0);
        check_flag("o_lckfrc", o_lckfrc, 1'b1);
        check_code("o_rqi code", rq_code_e'(o_rqi[RQI_W-1:1]), RQC_L2R);
        rx_ok_prev  = o_rx_ok;
        lckfrc_prev = o_lckfrc;
        for (int r = 0; r < n_rows; r++) run_row(r);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: src.f
source/lm_req_pkg.sv
source/lm_seq_pkg.sv
source/lm_req_if.sv
source/lm_input_sync.sv
source/lm_sequencer.sv
source/lm_request_port.sv
source/lane_master_top.sv
testbench/tb_clk_gen.sv
testbench/lane_master_checker.sv
testbench/tb_lane_master.sv

// File: Bender.yml
package:
  name: lane_master

sources:
  - source/lm_req_pkg.sv
  - source/lm_seq_pkg.sv
  - source/lm_req_if.sv
  - source/lm_input_sync.sv
  - source/lm_sequencer.sv
  - source/lm_request_port.sv
  - source/lane_master_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/lane_master_checker.sv
      - testbench/tb_lane_master.sv
